/* approx_fir.f */
+incdir+common
+incdir+tb
common/approx_fir_pkg.sv
hw/bw_approx_mult/bw_approx_mult.sv
hw/tap_line.sv
hw/sum_tree.sv
hw/approx_fir.sv
tb/approx_fir_tb.sv

/* common/approx_fir_config.svh */
`ifndef APPROX_FIR_CONFIG_SVH
`define APPROX_FIR_CONFIG_SVH

// Number of filter taps. Any value of 2 or more works.
`define FIR_TAPS 4

// Product width plus growth for the tap sum.
`define ACC_W (32 + $clog2(`FIR_TAPS))

`endif

/* common/approx_fir_pkg.sv */
`include "approx_fir_config.svh"

package approx_fir_pkg;

    typedef logic signed [15:0] sample_t;   // Sample or coefficient.
    typedef logic signed [31:0] product_t;  // Approximate multiplier result.
    typedef logic signed [`ACC_W-1:0] acc_t;

    typedef logic [$clog2(`FIR_TAPS)-1:0] tap_addr_t;

    // Coefficient write port.
    typedef struct packed {
        logic      we;
        tap_addr_t addr;
        sample_t   data;
    } coef_wr_t;

    // Tap line state seen by the multipliers.
    typedef struct packed {
        sample_t [`FIR_TAPS-1:0] samples;  // Index 0 is the newest.
        sample_t [`FIR_TAPS-1:0] coefs;
        logic                    valid;    // New sample shifted in.
    } tap_bus_t;

endpackage

/* hw/approx_fir.sv */
`timescale 1ns/1ps

`include "approx_fir_config.svh"

module approx_fir (
    input                           clk,
    input                           rst_n,
    input                           sample_valid,
    input  approx_fir_pkg::sample_t  sample,
    input  approx_fir_pkg::coef_wr_t coef_wr,
    output approx_fir_pkg::acc_t     result,
    output logic                    result_valid
);

    import approx_fir_pkg::*;

    tap_bus_t                      taps;
    product_t [`FIR_TAPS-1:0]      products;

    tap_line u_tap_line (
        .clk          (clk),
        .rst_n        (rst_n),
        .sample_valid (sample_valid),
        .sample       (sample),
        .coef_wr      (coef_wr),
        .taps         (taps)
    );

    // One approximate multiplier per tap.
    for (genvar k = 0; k < `FIR_TAPS; k++) begin : g_tap
        bw_approx_mult u_mult (
            .x (taps.samples[k]),
            .y (taps.coefs[k]),
            .z (products[k])
        );
    end

    sum_tree u_sum_tree (
        .clk          (clk),
        .rst_n        (rst_n),
        .products     (products),
        .in_valid     (taps.valid),
        .result       (result),
        .result_valid (result_valid)
    );

endmodule

/* hw/bw_approx_mult/bw_approx_mult.sv */
`timescale 1ns/1ps

module bw_approx_mult (
    input  approx_fir_pkg::sample_t  x,
    input  approx_fir_pkg::sample_t  y,
    output approx_fir_pkg::product_t z
);

    logic [16:0] pp [16];   // Baugh-Wooley rows, row i from x[i].
    logic [20:0] cw [4];    // Compensation words for rows 0 to 5.
    logic [31:0] sum;

    // Partial-product rows.
    always_comb begin
        for (int i = 0; i < 15; i++) begin
            pp[i][14:0] = y[14:0] & {15{x[i]}};
            pp[i][15]   = ~(y[15] & x[i]);   // Inverted sign bit.
            pp[i][16]   = 1'b0;
        end
        pp[0][16] = 1'b1;
        // Last row inverts the magnitude bits instead.
        pp[15][14:0] = ~(y[14:0] & {15{x[15]}});
        pp[15][15]   = y[15] & x[15];
        pp[15][16]   = 1'b1;
    end

    // Fixed term table standing in for rows 0 to 5.
    always_comb begin
        for (int j = 0; j < 4; j++) begin
            cw[j] = '0;
        end

        cw[0][6]  = pp[0][6] ^ pp[1][5];
        cw[0][7]  = pp[0][6] & pp[1][5];
        cw[0][10] = pp[0][10] ^ pp[1][9];
        cw[0][12] = pp[2][9] & pp[3][8];
        cw[0][13] = pp[4][9] ^ pp[5][8];
        cw[0][14] = pp[0][14] ^ pp[1][13];
        cw[0][16] = pp[0][15] | pp[1][14];
        cw[0][17] = pp[1][15];
        cw[0][18] = pp[2][15] & pp[3][14];
        cw[0][19] = pp[4][14] & pp[5][13];
        cw[0][20] = pp[4][15] & pp[5][14];

        cw[1][7]  = pp[2][4] & pp[3][3];
        cw[1][16] = 1'b1;                   // Folded sign correction.
        cw[1][17] = pp[2][14] & pp[3][13];
        cw[1][18] = pp[3][15];
        cw[1][19] = pp[4][15] ^ pp[5][14];
        cw[1][20] = pp[5][15];

        cw[2][16] = pp[2][13] & pp[3][12];
        cw[2][17] = pp[2][15] ^ pp[3][14];
        cw[2][18] = pp[4][13] & pp[5][12];

        cw[3][17] = pp[4][13] ^ pp[5][12];
        cw[3][18] = pp[4][14] | pp[5][13];
    end

    // Exact sum of the upper rows plus compensation.
    always_comb begin
        sum = '0;
        for (int i = 6; i < 16; i++) begin
            sum = sum + (32'(pp[i]) << i);
        end
        for (int j = 0; j < 4; j++) begin
            sum = sum + 32'(cw[j]);
        end
    end

    assign z = sum;

endmodule

/* hw/sum_tree.sv */
`timescale 1ns/1ps

`include "approx_fir_config.svh"

module sum_tree (
    input                                           clk,
    input                                           rst_n,
    input  approx_fir_pkg::product_t [`FIR_TAPS-1:0] products,
    input                                           in_valid,
    output approx_fir_pkg::acc_t                     result,
    output logic                                    result_valid
);

    import approx_fir_pkg::*;

    localparam int N      = `FIR_TAPS;
    localparam int LEVELS = $clog2(N);
    localparam int PADDED = 1 << LEVELS;

    acc_t lvl [PADDED];
    acc_t sum;

    // Pairwise adder tree, reduced in place level by level.
    always_comb begin
        for (int i = 0; i < PADDED; i++) begin
            lvl[i] = (i < N) ? acc_t'(products[i]) : '0;   // Sign-extend.
        end
        for (int l = 0; l < LEVELS; l++) begin
            for (int i = 0; i < (PADDED >> (l + 1)); i++) begin
                lvl[i] = lvl[2*i] + lvl[2*i+1];
            end
        end
        sum = lvl[0];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
            result       <= '0;
        end else begin
            result_valid <= in_valid;
            if (in_valid) begin
                result <= sum;
            end
        end
    end

    // Fixed one-cycle strobe latency through the tree.
    a_valid_latency: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid == $past(in_valid))
        else $error("result_valid does not follow in_valid");

    a_result_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !result_valid |-> $stable(result))
        else $error("result changed without result_valid");

endmodule

/* hw/tap_line.sv */
`timescale 1ns/1ps

`include "approx_fir_config.svh"

module tap_line (
    input                           clk,
    input                           rst_n,
    input                           sample_valid,
    input  approx_fir_pkg::sample_t  sample,
    input  approx_fir_pkg::coef_wr_t coef_wr,
    output approx_fir_pkg::tap_bus_t taps
);

    import approx_fir_pkg::*;

    localparam int N = `FIR_TAPS;

    sample_t [N-1:0] hist;
    sample_t [N-1:0] coefs;
    logic            shift_q;

    // Sample history, newest at index 0.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hist    <= '0;
            shift_q <= 1'b0;
        end else begin
            shift_q <= sample_valid;
            if (sample_valid) begin
                hist[0] <= sample;
                for (int k = 1; k < N; k++) begin
                    hist[k] <= hist[k-1];
                end
            end
        end
    end

    // Lands on the same edge as a sample, so that sample already sees it.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            coefs <= '0;
        end else if (coef_wr.we) begin
            coefs[coef_wr.addr] <= coef_wr.data;
        end
    end

    assign taps.samples = hist;
    assign taps.coefs   = coefs;
    assign taps.valid   = shift_q;

    a_coef_addr: assert property (@(posedge clk) disable iff (!rst_n)
        coef_wr.we |-> (coef_wr.addr < N))
        else $error("coefficient write to tap %0d out of range", coef_wr.addr);

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the approx_fir testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -Wno-fatal \
    --top-module approx_fir_tb \
    -f approx_fir.f \
    -o Vapprox_fir_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vapprox_fir_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Test OK" sim.log; then
    exit 0
fi

echo "Pass message not found in sim.log"
exit 1

/* tb/approx_mult_model.svh */
`ifndef APPROX_MULT_MODEL_SVH
`define APPROX_MULT_MODEL_SVH

// One bit of the Baugh-Wooley array. Row i comes from a[i], column j from b[j].
function automatic logic bw_bit(input logic [15:0] a, input logic [15:0] b,
                                input int i, input int j);
    logic p;
    if (j == 16) begin
        return (i == 0) || (i == 15);   // Constant ones of rows 0 and 15.
    end
    p = a[i] & b[j];
    if (i == 15) begin
        return (j == 15) ? p : ~p;      // Last row inverts its low bits.
    end
    return (j == 15) ? ~p : p;
endfunction

// A single bit placed at its column weight.
function automatic logic [63:0] weighted(input logic t, input int col);
    return {63'd0, t} << col;
endfunction

// Approximate product of sample a and coefficient b, modulo 2**32.
function automatic logic [31:0] approx_mult_ref(input logic [15:0] a, input logic [15:0] b);
    logic [63:0] acc;
    acc = '0;

    // Rows 6 to 15 are exact.
    for (int i = 6; i < 16; i++) begin
        for (int j = 0; j < 17; j++) begin
            acc = acc + weighted(bw_bit(a, b, i, j), i + j);
        end
    end

    // Term table for rows 0 to 5, column by column.
    acc = acc + weighted(bw_bit(a, b, 0, 6) ^ bw_bit(a, b, 1, 5), 6);
    acc = acc + weighted(bw_bit(a, b, 0, 6) & bw_bit(a, b, 1, 5), 7);
    acc = acc + weighted(bw_bit(a, b, 2, 4) & bw_bit(a, b, 3, 3), 7);
    acc = acc + weighted(bw_bit(a, b, 0, 10) ^ bw_bit(a, b, 1, 9), 10);
    acc = acc + weighted(bw_bit(a, b, 2, 9) & bw_bit(a, b, 3, 8), 12);
    acc = acc + weighted(bw_bit(a, b, 4, 9) ^ bw_bit(a, b, 5, 8), 13);
    acc = acc + weighted(bw_bit(a, b, 0, 14) ^ bw_bit(a, b, 1, 13), 14);
    acc = acc + weighted(bw_bit(a, b, 0, 15) | bw_bit(a, b, 1, 14), 16);
    acc = acc + weighted(1'b1, 16);    // Sign correction.
    acc = acc + weighted(bw_bit(a, b, 2, 13) & bw_bit(a, b, 3, 12), 16);
    acc = acc + weighted(bw_bit(a, b, 1, 15), 17);
    acc = acc + weighted(bw_bit(a, b, 2, 14) & bw_bit(a, b, 3, 13), 17);
    acc = acc + weighted(bw_bit(a, b, 2, 15) ^ bw_bit(a, b, 3, 14), 17);
    acc = acc + weighted(bw_bit(a, b, 4, 13) ^ bw_bit(a, b, 5, 12), 17);
    acc = acc + weighted(bw_bit(a, b, 2, 15) & bw_bit(a, b, 3, 14), 18);
    acc = acc + weighted(bw_bit(a, b, 3, 15), 18);
    acc = acc + weighted(bw_bit(a, b, 4, 13) & bw_bit(a, b, 5, 12), 18);
    acc = acc + weighted(bw_bit(a, b, 4, 14) | bw_bit(a, b, 5, 13), 18);
    acc = acc + weighted(bw_bit(a, b, 4, 14) & bw_bit(a, b, 5, 13), 19);
    acc = acc + weighted(bw_bit(a, b, 4, 15) ^ bw_bit(a, b, 5, 14), 19);
    acc = acc + weighted(bw_bit(a, b, 4, 15) & bw_bit(a, b, 5, 14), 20);
    acc = acc + weighted(bw_bit(a, b, 5, 15), 20);

    return acc[31:0];
endfunction

`endif

/* tb/approx_fir_tb.sv */
`timescale 1ns/1ps

`include "approx_fir_config.svh"

module approx_fir_tb;

    import approx_fir_pkg::*;

    `include "approx_mult_model.svh"

    localparam int CLK_PERIOD = 4;
    localparam int N_IMPULSE  = `FIR_TAPS + 4;
    localparam int N_BURST    = 16;
    localparam int N_RANDOM   = 300;
    localparam int MAX_GAP    = 3;
    localparam int N_STREAM   = 12;
    localparam int N_EXTREME  = 9 * `FIR_TAPS;
    localparam int N_SAMPLES  = 1 + N_IMPULSE + N_BURST + N_RANDOM + N_STREAM + N_EXTREME;
    // Every sample may take a full gap; reset, idles and writes fit in the margin.
    localparam int WATCHDOG_CYCLES = N_SAMPLES * (MAX_GAP + 1) + 10 * `FIR_TAPS + 200;

    logic     clk;
    logic     rst_n;
    logic     sample_valid;
    sample_t  sample;
    coef_wr_t coef_wr;
    acc_t     result;
    logic     result_valid;

    sample_t model_hist [`FIR_TAPS];
    sample_t model_coef [`FIR_TAPS];
    acc_t    exp_q [$];     // Expected sums in strobe order.
    longint  due_q [$];     // Cycle at which each result is due.
    longint  cyc_count = 0;
    integer  seed = 57;

    sample_t extremes [3] = '{16'sh8000, 16'sh7fff, 16'shffff};

    approx_fir u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .sample_valid (sample_valid),
        .sample       (sample),
        .coef_wr      (coef_wr),
        .result       (result),
        .result_valid (result_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("error %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    // Sum of the approximate products over the modelled taps.
    function automatic acc_t fir_expected();
        acc_t        s;
        logic [31:0] p;
        s = '0;
        for (int k = 0; k < `FIR_TAPS; k++) begin
            p = approx_mult_ref(model_hist[k], model_coef[k]);
            s = s + acc_t'($signed(p));
        end
        return s;
    endfunction

    function automatic sample_t random_sample();
        return sample_t'($random(seed));
    endfunction

    function automatic tap_addr_t pick_tap();
        return tap_addr_t'($unsigned($random(seed)) % `FIR_TAPS);
    endfunction

    function automatic logic coin_flip();
        return ($unsigned($random(seed)) % 4) == 0;   // One in four.
    endfunction

    // One clock of stimulus. The model sees the write before the shift.
    task automatic drive_cycle(input logic valid, input sample_t s, input logic we,
                               input tap_addr_t addr, input sample_t data);
        @(posedge clk);
        sample_valid <= valid;
        sample       <= s;
        coef_wr.we   <= we;
        coef_wr.addr <= addr;
        coef_wr.data <= data;
        if (we) begin
            model_coef[addr] = data;
        end
        if (valid) begin
            for (int k = `FIR_TAPS - 1; k > 0; k--) begin
                model_hist[k] = model_hist[k-1];
            end
            model_hist[0] = s;
            exp_q.push_back(fir_expected());
        end
    endtask

    task automatic send_sample(input sample_t s);
        drive_cycle(1'b1, s, 1'b0, '0, '0);
    endtask

    task automatic write_coef(input tap_addr_t addr, input sample_t data);
        drive_cycle(1'b0, '0, 1'b1, addr, data);
    endtask

    task automatic idle_for(input int n);
        repeat (n) drive_cycle(1'b0, '0, 1'b0, '0, '0);
    endtask

    // Result monitor, sampled mid-cycle.
    always @(negedge clk) begin
        cyc_count = cyc_count + 1;
        if (sample_valid) begin
            due_q.push_back(cyc_count + 2);
        end
        if (result_valid) begin
            if (exp_q.size() == 0 || due_q.size() == 0) begin
                fail_run("result_valid pulsed with no sample in flight");
            end else begin
                check_value("result", result, exp_q.pop_front());
                check_value("result_valid cycle", cyc_count, due_q.pop_front());
            end
        end
        if (due_q.size() != 0 && due_q[0] < cyc_count) begin
            fail_run("a sample strobe produced no result");
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        fail_run("watchdog expired before the test sequence finished");
    end

    initial begin
        int gap;
        for (int k = 0; k < `FIR_TAPS; k++) begin
            model_hist[k] = '0;
            model_coef[k] = '0;
        end
        rst_n        = 1'b0;
        sample_valid = 1'b0;
        sample       = '0;
        coef_wr      = '0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        // Quiet after reset, then one sample against zero coefficients.
        idle_for(10);
        send_sample(16'sh1234);
        idle_for(6);

        // Impulse response.
        for (int k = 0; k < `FIR_TAPS; k++) begin
            write_coef(tap_addr_t'(k), sample_t'((k + 1) * 4099 - 9000));
        end
        send_sample(16'sd1);
        repeat (N_IMPULSE - 1) send_sample('0);
        idle_for(6);

        // Back-to-back burst.
        repeat (N_BURST) send_sample(random_sample());
        idle_for(6);

        // Random stream with gaps and random writes, some on strobe edges.
        for (int n = 0; n < N_RANDOM; n++) begin
            gap = $unsigned($random(seed)) % (MAX_GAP + 1);
            repeat (gap) drive_cycle(1'b0, '0, coin_flip(), pick_tap(), random_sample());
            drive_cycle(1'b1, random_sample(), coin_flip(), pick_tap(), random_sample());
        end
        idle_for(6);

        // A write on every strobe edge of a streaming burst.
        for (int n = 0; n < N_STREAM; n++) begin
            drive_cycle(1'b1, random_sample(), 1'b1, tap_addr_t'(n % `FIR_TAPS),
                        random_sample());
        end
        idle_for(6);

        // Extreme operands in all combinations.
        for (int c = 0; c < 3; c++) begin
            for (int s = 0; s < 3; s++) begin
                for (int k = 0; k < `FIR_TAPS; k++) begin
                    write_coef(tap_addr_t'(k), extremes[c]);
                end
                repeat (`FIR_TAPS) send_sample(extremes[s]);
            end
        end

        idle_for(10);
        if (exp_q.size() != 0) begin
            fail_run("results still missing at the end of the run");
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule
